//--- Makefile
BIN := obj_dir/VfragmentPipelineTb
SOURCES := $(wildcard design/*.sv verif/*.sv verif/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): fragmentPipeline.f $(SOURCES)
	verilator --binary --timing --assert -f fragmentPipeline.f \
		--top-module fragmentPipelineTb

# Fails when the simulator errors out or the log holds the fail message
run: $(BIN)
	./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
		test $$status -eq 0 && ! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/fragmentOpsPkg.sv
package fragmentOpsPkg;

    //////////////////////////////////////////////////////////////////////
    // Compare functions
    //////////////////////////////////////////////////////////////////////

    // Encoding follows the usual GL ordering
    typedef enum logic [2:0] {
        NEVER    = 3'd0,
        LESS     = 3'd1,
        EQUAL    = 3'd2,
        LEQUAL   = 3'd3,
        GREATER  = 3'd4,
        NOTEQUAL = 3'd5,
        GEQUAL   = 3'd6,
        ALWAYS   = 3'd7
    } testFunc_e;

    //////////////////////////////////////////////////////////////////////
    // Pipeline constants
    //////////////////////////////////////////////////////////////////////

    // Cycles from read index to valid depth data
    localparam int MEM_READ_LATENCY = 2;

    // Pipeline is 5 deep, rounded up for margin
    localparam int MAX_IN_FLIGHT = 8;

    // Wide enough for depth; alpha is zero extended
    localparam int COMPARE_WIDTH = pixelFormatPkg::DEPTH_WIDTH;

    // Shared by the alpha and depth tests
    function automatic logic compareTest(
        input logic [COMPARE_WIDTH-1:0] value,
        input logic [COMPARE_WIDTH-1:0] refValue,
        input testFunc_e                func
    );
        logic pass;
        case (func)
            NEVER:    pass = 1'b0;
            LESS:     pass = value < refValue;
            EQUAL:    pass = value == refValue;
            LEQUAL:   pass = value <= refValue;
            GREATER:  pass = value > refValue;
            NOTEQUAL: pass = value != refValue;
            GEQUAL:   pass = value >= refValue;
            default:  pass = 1'b1;
        endcase
        return pass;
    endfunction

endpackage

//--- design/fragmentPipeline.sv
`timescale 1ns/1ps

module fragmentPipeline
(
    input  logic                                       clk,
    input  logic                                       reset,

    // Fragment input
    input  logic                                       fragValid,
    input  pixelFormatPkg::fbIndex_t                   fragIndex,
    input  pixelFormatPkg::rawDepth_t                  fragDepth,
    input  pixelFormatPkg::rawColor_t                  fragColor,

    // Configuration, stable while fragments are in flight
    input  fragmentOpsPkg::testFunc_e                  alphaFunc,
    input  logic [pixelFormatPkg::SUB_PIXEL_WIDTH-1:0] alphaRef,
    input  fragmentOpsPkg::testFunc_e                  depthFunc,
    input  logic                                       depthTestEnable,

    // Depth buffer read
    output pixelFormatPkg::fbIndex_t                   depthIndexRead,
    input  pixelFormatPkg::depth_t                     depthIn,

    // Color buffer write
    output pixelFormatPkg::fbIndex_t                   colorIndexWrite,
    output pixelFormatPkg::pixel_t                     colorOut,
    output logic                                       colorWriteEnable,

    // Depth buffer write
    output pixelFormatPkg::fbIndex_t                   depthIndexWrite,
    output pixelFormatPkg::depth_t                     depthOut,
    output logic                                       depthWriteEnable,

    output logic                                       pixelInPipeline
);

    logic                        setupValid;
    pixelFormatPkg::fragRecord_t setupRecord;
    logic                        delayedValid;
    pixelFormatPkg::fragRecord_t delayedRecord;
    logic                        writeBackDone;

    //////////////////////////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////////////////////////

    fragmentSetup u_setup (
        .clk            (clk),
        .reset          (reset),
        .fragValid      (fragValid),
        .fragIndex      (fragIndex),
        .fragDepth      (fragDepth),
        .fragColor      (fragColor),
        .setupValid     (setupValid),
        .setupRecord    (setupRecord),
        .depthIndexRead (depthIndexRead)
    );

    // Waits out the depth memory read
    memoryLatencyDelay u_delay (
        .clk           (clk),
        .reset         (reset),
        .setupValid    (setupValid),
        .setupRecord   (setupRecord),
        .delayedValid  (delayedValid),
        .delayedRecord (delayedRecord)
    );

    fragmentTestWrite u_testWrite (
        .clk              (clk),
        .reset            (reset),
        .delayedValid     (delayedValid),
        .delayedRecord    (delayedRecord),
        .depthIn          (depthIn),
        .alphaFunc        (alphaFunc),
        .alphaRef         (alphaRef),
        .depthFunc        (depthFunc),
        .depthTestEnable  (depthTestEnable),
        .colorIndexWrite  (colorIndexWrite),
        .depthIndexWrite  (depthIndexWrite),
        .colorOut         (colorOut),
        .depthOut         (depthOut),
        .colorWriteEnable (colorWriteEnable),
        .depthWriteEnable (depthWriteEnable),
        .writeBackDone    (writeBackDone)
    );

    fragmentTracker u_tracker (
        .clk             (clk),
        .reset           (reset),
        .fragValid       (fragValid),
        .writeBackDone   (writeBackDone),
        .pixelInPipeline (pixelInPipeline)
    );

endmodule

//--- design/fragmentSetup.sv
`timescale 1ns/1ps

module fragmentSetup
(
    input  logic                        clk,
    input  logic                        reset,

    // Incoming fragment strobe
    input  logic                        fragValid,
    input  pixelFormatPkg::fbIndex_t    fragIndex,
    input  pixelFormatPkg::rawDepth_t   fragDepth,
    input  pixelFormatPkg::rawColor_t   fragColor,

    // Towards the latency buffer
    output logic                        setupValid,
    output pixelFormatPkg::fragRecord_t setupRecord,

    // Depth buffer read port
    output pixelFormatPkg::fbIndex_t    depthIndexRead
);

    //////////////////////////////////////////////////////////////////////
    // Clamping
    //////////////////////////////////////////////////////////////////////

    // Raw depth has as many fraction bits as the buffer value
    function automatic pixelFormatPkg::depth_t clampDepth(
        input pixelFormatPkg::rawDepth_t raw
    );
        pixelFormatPkg::depth_t result;
        if (raw[pixelFormatPkg::RAW_DEPTH_WIDTH-1])
        begin
            // Behind the near plane
            result = '0;
        end
        else if (|raw[pixelFormatPkg::RAW_DEPTH_WIDTH-2:pixelFormatPkg::DEPTH_WIDTH])
        begin
            // At or beyond 1.0
            result = '1;
        end
        else
        begin
            result = raw[pixelFormatPkg::DEPTH_WIDTH-1:0];
        end
        return result;
    endfunction

    // Any integer bit saturates the channel to full intensity
    function automatic logic [pixelFormatPkg::SUB_PIXEL_WIDTH-1:0] clampChannel(
        input logic [pixelFormatPkg::RAW_CHANNEL_WIDTH-1:0] raw
    );
        logic [pixelFormatPkg::SUB_PIXEL_WIDTH-1:0] result;
        if (|raw[pixelFormatPkg::RAW_CHANNEL_WIDTH-1:pixelFormatPkg::SUB_PIXEL_WIDTH])
            result = '1;
        else
            result = raw[pixelFormatPkg::SUB_PIXEL_WIDTH-1:0];
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            setupValid <= 1'b0;
        else
            setupValid <= fragValid;
    end

    // Read is issued in the same cycle the record leaves this stage
    always_ff @(posedge clk)
    begin
        if (fragValid)
        begin
            setupRecord.index   <= fragIndex;
            setupRecord.depth   <= clampDepth(fragDepth);
            setupRecord.color.r <= clampChannel(fragColor.r);
            setupRecord.color.g <= clampChannel(fragColor.g);
            setupRecord.color.b <= clampChannel(fragColor.b);
            setupRecord.color.a <= clampChannel(fragColor.a);
            depthIndexRead      <= fragIndex;
        end
    end

endmodule

//--- design/fragmentTestWrite.sv
`timescale 1ns/1ps

module fragmentTestWrite
(
    input  logic                                       clk,
    input  logic                                       reset,

    // Fragment together with its stored depth
    input  logic                                       delayedValid,
    input  pixelFormatPkg::fragRecord_t                delayedRecord,
    input  pixelFormatPkg::depth_t                     depthIn,

    // Test configuration
    input  fragmentOpsPkg::testFunc_e                  alphaFunc,
    input  logic [pixelFormatPkg::SUB_PIXEL_WIDTH-1:0] alphaRef,
    input  fragmentOpsPkg::testFunc_e                  depthFunc,
    input  logic                                       depthTestEnable,

    // Framebuffer write-back
    output pixelFormatPkg::fbIndex_t                   colorIndexWrite,
    output pixelFormatPkg::fbIndex_t                   depthIndexWrite,
    output pixelFormatPkg::pixel_t                     colorOut,
    output pixelFormatPkg::depth_t                     depthOut,
    output logic                                       colorWriteEnable,
    output logic                                       depthWriteEnable,
    output logic                                       writeBackDone
);

    localparam int PAD_WIDTH = fragmentOpsPkg::COMPARE_WIDTH - pixelFormatPkg::SUB_PIXEL_WIDTH;

    logic                        testValid;
    pixelFormatPkg::fragRecord_t testRecord;
    logic                        alphaPass;
    logic                        depthPass;
    logic                        writeColor;

    //////////////////////////////////////////////////////////////////////
    // Stage 1: alpha and depth tests
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            testValid <= 1'b0;
        else
            testValid <= delayedValid;
    end

    always_ff @(posedge clk)
    begin
        testRecord <= delayedRecord;
        alphaPass  <= fragmentOpsPkg::compareTest({{PAD_WIDTH{1'b0}}, delayedRecord.color.a},
                                                  {{PAD_WIDTH{1'b0}}, alphaRef}, alphaFunc);
        depthPass  <= fragmentOpsPkg::compareTest(delayedRecord.depth, depthIn, depthFunc);
    end

    // Disabled depth testing lets every fragment through
    assign writeColor = testValid && alphaPass && (depthPass || !depthTestEnable);

    //////////////////////////////////////////////////////////////////////
    // Stage 2: write-back
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            colorWriteEnable <= 1'b0;
            depthWriteEnable <= 1'b0;
            writeBackDone    <= 1'b0;
        end
        else
        begin
            colorWriteEnable <= writeColor;
            depthWriteEnable <= writeColor && depthTestEnable;
            writeBackDone    <= testValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (testValid)
        begin
            colorIndexWrite <= testRecord.index;
            depthIndexWrite <= testRecord.index;
            colorOut        <= testRecord.color;
            depthOut        <= testRecord.depth;
        end
    end

endmodule

//--- design/fragmentTracker.sv
`timescale 1ns/1ps

module fragmentTracker
(
    input  logic clk,
    input  logic reset,
    input  logic fragValid,
    input  logic writeBackDone,
    output logic pixelInPipeline
);

    localparam int COUNT_WIDTH = $clog2(fragmentOpsPkg::MAX_IN_FLIGHT + 1);

    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] nextCount;

    // Entry and exit in the same cycle cancel out
    always_comb
    begin
        nextCount = count;
        case ({fragValid, writeBackDone})
            2'b10:   nextCount = count + 1'b1;
            2'b01:   nextCount = count - 1'b1;
            default: nextCount = count;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count           <= '0;
            pixelInPipeline <= 1'b0;
        end
        else
        begin
            count           <= nextCount;
            pixelInPipeline <= nextCount != '0;
        end
    end

endmodule

//--- design/memoryLatencyDelay.sv
`timescale 1ns/1ps

module memoryLatencyDelay
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        setupValid,
    input  pixelFormatPkg::fragRecord_t setupRecord,

    // Lines up with depthIn from the memory
    output logic                        delayedValid,
    output pixelFormatPkg::fragRecord_t delayedRecord
);

    localparam int DEPTH = fragmentOpsPkg::MEM_READ_LATENCY;

    logic                        validPipe  [DEPTH];
    pixelFormatPkg::fragRecord_t recordPipe [DEPTH];

    // Valid bits, one per stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                validPipe[i] <= 1'b0;
        end
        else
        begin
            validPipe[0] <= setupValid;
            for (int i = 1; i < DEPTH; i++)
                validPipe[i] <= validPipe[i-1];
        end
    end

    // Records shift unconditionally, each tagged by its valid bit
    always_ff @(posedge clk)
    begin
        recordPipe[0] <= setupRecord;
        for (int i = 1; i < DEPTH; i++)
            recordPipe[i] <= recordPipe[i-1];
    end

    assign delayedValid  = validPipe[DEPTH-1];
    assign delayedRecord = recordPipe[DEPTH-1];

endmodule

//--- design/pixelFormatPkg.sv
package pixelFormatPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // One color channel in the framebuffer
    localparam int SUB_PIXEL_WIDTH = 8;

    // Raw channel is unsigned fixed point, 8 fraction bits
    localparam int RAW_CHANNEL_WIDTH = 16;

    // Raw depth is signed fixed point, 16 fraction bits
    localparam int RAW_DEPTH_WIDTH = 32;

    localparam int DEPTH_WIDTH = 16;
    localparam int FB_INDEX_WIDTH = 14;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Red in the top byte, alpha in the bottom byte
    typedef struct packed {
        logic [SUB_PIXEL_WIDTH-1:0] r;
        logic [SUB_PIXEL_WIDTH-1:0] g;
        logic [SUB_PIXEL_WIDTH-1:0] b;
        logic [SUB_PIXEL_WIDTH-1:0] a;
    } pixel_t;

    typedef struct packed {
        logic [RAW_CHANNEL_WIDTH-1:0] r;
        logic [RAW_CHANNEL_WIDTH-1:0] g;
        logic [RAW_CHANNEL_WIDTH-1:0] b;
        logic [RAW_CHANNEL_WIDTH-1:0] a;
    } rawColor_t;

    typedef logic signed [RAW_DEPTH_WIDTH-1:0] rawDepth_t;
    typedef logic [DEPTH_WIDTH-1:0] depth_t;
    typedef logic [FB_INDEX_WIDTH-1:0] fbIndex_t;

    // Fragment as it travels through the pipeline, 62 bits
    typedef struct packed {
        fbIndex_t index;
        depth_t   depth;
        pixel_t   color;
    } fragRecord_t;

endpackage

//--- fragmentPipeline.f
+incdir+verif
design/pixelFormatPkg.sv
design/fragmentOpsPkg.sv
design/fragmentSetup.sv
design/memoryLatencyDelay.sv
design/fragmentTestWrite.sv
design/fragmentTracker.sv
design/fragmentPipeline.sv
verif/fragmentPipelineSva.sv
verif/fragmentPipelineTb.sv

//--- verif/fragmentPipelineSva.sv
`timescale 1ns/1ps

module fragmentPipelineSva
(
    input logic clk,
    input logic reset,
    input logic colorWriteEnable,
    input logic depthWriteEnable,
    input logic writeBackDone,
    input logic pixelInPipeline
);

    // Depth is only ever written together with its color
    depthNeedsColor: assert property (@(posedge clk) disable iff (reset)
        depthWriteEnable |-> colorWriteEnable)
        else $error("depthWriteEnable high without colorWriteEnable");

    // Both enables clear on a reset edge
    quietInReset: assert property (@(posedge clk)
        $past(reset) |-> !colorWriteEnable && !depthWriteEnable)
        else $error("write enable high while in reset");

    // A finishing fragment is still counted by the tracker
    trackerCoversWriteBack: assert property (@(posedge clk) disable iff (reset)
        writeBackDone |-> pixelInPipeline)
        else $error("writeBackDone fired with pixelInPipeline low");

endmodule

// Watches the write-back stage and the tracker through the top level wires
bind fragmentPipeline fragmentPipelineSva u_sva (
    .clk              (clk),
    .reset            (reset),
    .colorWriteEnable (colorWriteEnable),
    .depthWriteEnable (depthWriteEnable),
    .writeBackDone    (writeBackDone),
    .pixelInPipeline  (pixelInPipeline)
);

//--- verif/fragmentTests.svh
// Random raw values through the clamp stage with color written and no depth written
task automatic testClamping();
    pixelFormatPkg::rawDepth_t depth;
    pixelFormatPkg::rawColor_t color;
    pixelFormatPkg::fbIndex_t  index;
    logic [31:0]               word;
    alphaFunc = fragmentOpsPkg::ALWAYS;
    depthFunc = fragmentOpsPkg::ALWAYS;
    depthTestEnable = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
        word = randomWord();
        case (i % 4)
            0:       depth = word | 32'h8000_0000;
            1:       depth = {1'b0, word[30:0]} | 32'h0001_0000;
            2:       depth = {16'h0000, word[15:0]};
            default: depth = word;
        endcase
        // Exactly 1.0 sits on the saturation boundary
        if (i == 5)
            depth = 32'sh0001_0000;
        word = randomWord();
        color.r = word[16] ? {8'h00, word[7:0]} : word[15:0];
        color.g = word[17] ? {8'h00, word[15:8]} : word[31:16];
        word = randomWord();
        color.b = word[16] ? {8'h00, word[7:0]} : word[15:0];
        color.a = word[17] ? {8'h00, word[15:8]} : word[31:16];
        index = 14'h0100 + 14'(i);
        runFragment(index, depth, color, 1'b1, 1'b0);
    end
endtask

// Alpha below, equal to and above the reference for every function
task automatic testAlpha();
    fragmentOpsPkg::testFunc_e func;
    pixelFormatPkg::rawColor_t color;
    logic [7:0]                alpha;
    logic                      pass;
    depthTestEnable = 1'b0;
    alphaRef = 8'h80;
    color = {16'h0040, 16'h0080, 16'h00C0, 16'h0000};
    func = fragmentOpsPkg::NEVER;
    for (int f = 0; f < 8; f++)
    begin
        alphaFunc = func;
        for (int k = 0; k < 3; k++)
        begin
            alpha = 8'h7F + 8'(k);
            color.a = {8'h00, alpha};
            pass = funcPasses({8'h00, alpha}, {8'h00, alphaRef}, func);
            runFragment(14'h0180, 32'sh0000_8000, color, pass, 1'b0);
        end
        func = func.next();
    end
endtask

// Each test fragment reads a depth that an earlier write-back stored
task automatic testDepth();
    fragmentOpsPkg::testFunc_e func;
    pixelFormatPkg::rawColor_t color;
    pixelFormatPkg::fbIndex_t  index;
    pixelFormatPkg::depth_t    stored;
    pixelFormatPkg::depth_t    fragZ;
    logic                      pass;
    depthTestEnable = 1'b1;
    alphaFunc = fragmentOpsPkg::ALWAYS;
    color = {16'h0011, 16'h0022, 16'h0033, 16'h00FF};
    index = 14'h0200;
    func = fragmentOpsPkg::NEVER;
    for (int f = 0; f < 8; f++)
    begin
        for (int k = 0; k < 3; k++)
        begin
            stored = 16'h3000 + 16'(f * 64);
            depthFunc = fragmentOpsPkg::ALWAYS;
            runFragment(index, {16'h0000, stored}, color, 1'b1, 1'b1);
            // Nearer, equal and farther
            fragZ = stored - 16'd1 + 16'(k);
            depthFunc = func;
            pass = funcPasses(fragZ, stored, func);
            runFragment(index, {16'h0000, fragZ}, color, pass, pass);
            index = index + 14'd1;
        end
        func = func.next();
    end
endtask

// Six fragments on consecutive cycles with each checked in its own slot
task automatic testBurst();
    pixelFormatPkg::rawColor_t colors  [6];
    pixelFormatPkg::rawDepth_t depths  [6];
    pixelFormatPkg::fbIndex_t  indices [6];
    logic [31:0]               word;
    int                        waited;
    int                        slot;
    alphaFunc = fragmentOpsPkg::ALWAYS;
    depthFunc = fragmentOpsPkg::ALWAYS;
    depthTestEnable = 1'b1;
    for (int i = 0; i < 6; i++)
    begin
        word = randomWord();
        indices[i] = 14'h0300 + 14'(i);
        depths[i] = {16'h0000, word[15:0]};
        colors[i] = {word, randomWord()};
    end
    // Fragment c is presented in the cycle that ends at loop edge c
    for (int c = 0; c < 6 + STROBE_DELAY - 1; c++)
    begin
        fragValid = c < 6;
        if (c < 6)
        begin
            fragIndex = indices[c];
            fragDepth = depths[c];
            fragColor = colors[c];
        end
        @(posedge clk);
        #1;
        checkFlag(pixelInPipeline, 1'b1, "pixelInPipeline during burst");
        if (c < STROBE_DELAY - 1)
        begin
            checkFlag(colorWriteEnable, 1'b0, "colorWriteEnable before first slot");
        end
        else
        begin
            slot = c - (STROBE_DELAY - 1);
            checkFlag(colorWriteEnable, 1'b1, "colorWriteEnable in burst slot");
            checkFlag(depthWriteEnable, 1'b1, "depthWriteEnable in burst slot");
            checkIndex(colorIndexWrite, indices[slot], "colorIndexWrite in burst");
            checkPixel(colorOut, expectColor(colors[slot]), "colorOut in burst");
            checkDepth(depthOut, expectDepth(depths[slot]), "depthOut in burst");
        end
    end
    waited = 0;
    while (pixelInPipeline && waited < WAIT_LIMIT)
    begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (pixelInPipeline)
    begin
        $display("Timeout: pixelInPipeline still high %0d cycles after the burst", waited);
        timeoutCount++;
    end
endtask

//--- verif/fragmentPipelineTb.sv
`timescale 1ns/1ps

module fragmentPipelineTb;

    localparam int STROBE_DELAY = 5;
    localparam int WAIT_LIMIT = 40;
    localparam int MEM_WORDS = 1 << pixelFormatPkg::FB_INDEX_WIDTH;
    localparam int LATENCY = fragmentOpsPkg::MEM_READ_LATENCY;

    logic                                       clk;
    logic                                       reset;
    logic                                       fragValid;
    pixelFormatPkg::fbIndex_t                   fragIndex;
    pixelFormatPkg::rawDepth_t                  fragDepth;
    pixelFormatPkg::rawColor_t                  fragColor;
    fragmentOpsPkg::testFunc_e                  alphaFunc;
    logic [pixelFormatPkg::SUB_PIXEL_WIDTH-1:0] alphaRef;
    fragmentOpsPkg::testFunc_e                  depthFunc;
    logic                                       depthTestEnable;
    pixelFormatPkg::fbIndex_t                   depthIndexRead;
    pixelFormatPkg::depth_t                     depthIn;
    pixelFormatPkg::fbIndex_t                   colorIndexWrite;
    pixelFormatPkg::pixel_t                     colorOut;
    logic                                       colorWriteEnable;
    pixelFormatPkg::fbIndex_t                   depthIndexWrite;
    pixelFormatPkg::depth_t                     depthOut;
    logic                                       depthWriteEnable;
    logic                                       pixelInPipeline;

    int     mismatchCount;
    int     timeoutCount;
    integer seed;

    pixelFormatPkg::depth_t depthMem [MEM_WORDS];
    pixelFormatPkg::depth_t readPipe [LATENCY];

    fragmentPipeline u_dut (
        .clk              (clk),
        .reset            (reset),
        .fragValid        (fragValid),
        .fragIndex        (fragIndex),
        .fragDepth        (fragDepth),
        .fragColor        (fragColor),
        .alphaFunc        (alphaFunc),
        .alphaRef         (alphaRef),
        .depthFunc        (depthFunc),
        .depthTestEnable  (depthTestEnable),
        .depthIndexRead   (depthIndexRead),
        .depthIn          (depthIn),
        .colorIndexWrite  (colorIndexWrite),
        .colorOut         (colorOut),
        .colorWriteEnable (colorWriteEnable),
        .depthIndexWrite  (depthIndexWrite),
        .depthOut         (depthOut),
        .depthWriteEnable (depthWriteEnable),
        .pixelInPipeline  (pixelInPipeline)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Depth memory model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (reset)
        begin
            // Background value differs for every address
            for (int a = 0; a < MEM_WORDS; a++)
                depthMem[a] <= 16'(a) ^ 16'h5A5A;
        end
        else if (depthWriteEnable)
        begin
            depthMem[depthIndexWrite] <= depthOut;
        end
        readPipe[0] <= depthMem[depthIndexRead];
        for (int i = 1; i < LATENCY; i++)
            readPipe[i] <= readPipe[i-1];
    end

    assign depthIn = readPipe[LATENCY-1];

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkPixel(input pixelFormatPkg::pixel_t got,
                              input pixelFormatPkg::pixel_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkDepth(input pixelFormatPkg::depth_t got,
                              input pixelFormatPkg::depth_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkIndex(input pixelFormatPkg::fbIndex_t got,
                              input pixelFormatPkg::fbIndex_t exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    task automatic checkFlag(input bit got, input bit exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
            mismatchCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] randomWord();
        return $random(seed);
    endfunction

    // Signed 16.16 input clamped to a 0.16 buffer value
    function automatic pixelFormatPkg::depth_t expectDepth(input pixelFormatPkg::rawDepth_t raw);
        if (raw < 0)
            return '0;
        if (raw >= 32'sh0001_0000)
            return '1;
        return raw[15:0];
    endfunction

    function automatic logic [7:0] expectChannel(input logic [15:0] raw);
        if (raw > 16'd255)
            return 8'hFF;
        return raw[7:0];
    endfunction

    function automatic pixelFormatPkg::pixel_t expectColor(input pixelFormatPkg::rawColor_t raw);
        pixelFormatPkg::pixel_t result;
        result.r = expectChannel(raw.r);
        result.g = expectChannel(raw.g);
        result.b = expectChannel(raw.b);
        result.a = expectChannel(raw.a);
        return result;
    endfunction

    function automatic logic funcPasses(input logic [15:0] value, input logic [15:0] refValue,
                                        input fragmentOpsPkg::testFunc_e func);
        logic below;
        logic same;
        logic pass;
        below = value < refValue;
        same = value == refValue;
        case (func)
            fragmentOpsPkg::NEVER:    pass = 1'b0;
            fragmentOpsPkg::LESS:     pass = below;
            fragmentOpsPkg::EQUAL:    pass = same;
            fragmentOpsPkg::LEQUAL:   pass = below || same;
            fragmentOpsPkg::GREATER:  pass = !below && !same;
            fragmentOpsPkg::NOTEQUAL: pass = !same;
            fragmentOpsPkg::GEQUAL:   pass = !below;
            default:                  pass = 1'b1;
        endcase
        return pass;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Fragment driving
    //////////////////////////////////////////////////////////////////////

    // Called just after a rising edge and returns just after the sampling edge
    task automatic sendFragment(input pixelFormatPkg::fbIndex_t index,
                                input pixelFormatPkg::rawDepth_t depth,
                                input pixelFormatPkg::rawColor_t color);
        fragValid = 1'b1;
        fragIndex = index;
        fragDepth = depth;
        fragColor = color;
        @(posedge clk);
        #1;
        fragValid = 1'b0;
    endtask

    // Follows one fragment to its write-back slot and checks it there
    task automatic runFragment(input pixelFormatPkg::fbIndex_t index,
                               input pixelFormatPkg::rawDepth_t depth,
                               input pixelFormatPkg::rawColor_t color,
                               input bit expColor, input bit expDepth);
        int cycles;
        sendFragment(index, depth, color);
        checkIndex(depthIndexRead, index, "depthIndexRead");
        // The cycle that presented the fragment is the first of its delay
        cycles = 1;
        // A rejected fragment has no strobe so only its slot is waited out
        while (!colorWriteEnable && cycles < (expColor ? WAIT_LIMIT : STROBE_DELAY))
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (expColor && !colorWriteEnable)
        begin
            $display("Timeout: no color write for index %h after %0d cycles", index, cycles);
            timeoutCount++;
        end
        else
        begin
            if (cycles != STROBE_DELAY)
            begin
                $display("MISMATCH at %0t ns: write slot after %0d cycles, expected %0d",
                         $time, cycles, STROBE_DELAY);
                mismatchCount++;
            end
            checkFlag(colorWriteEnable, expColor, "colorWriteEnable");
            checkFlag(depthWriteEnable, expDepth, "depthWriteEnable");
            checkIndex(colorIndexWrite, index, "colorIndexWrite");
            checkIndex(depthIndexWrite, index, "depthIndexWrite");
            checkPixel(colorOut, expectColor(color), "colorOut");
            checkDepth(depthOut, expectDepth(depth), "depthOut");
        end
    endtask

    `include "fragmentTests.svh"

    initial
    begin
        seed = 25047;
        mismatchCount = 0;
        timeoutCount = 0;
        reset = 1'b1;
        fragValid = 1'b0;
        fragIndex = '0;
        fragDepth = '0;
        fragColor = '0;
        alphaFunc = fragmentOpsPkg::ALWAYS;
        alphaRef = '0;
        depthFunc = fragmentOpsPkg::ALWAYS;
        depthTestEnable = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        checkFlag(pixelInPipeline, 1'b0, "pixelInPipeline after reset");
        checkFlag(colorWriteEnable, 1'b0, "colorWriteEnable after reset");
        testClamping();
        testAlpha();
        testDepth();
        testBurst();
        $display("Errors: %0d mismatches, %0d timeouts", mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
